// ==== be_defs.svh ====
`ifndef BE_DEFS_SVH
`define BE_DEFS_SVH

// Datapath widths
`define BE_VADDR_WIDTH 32
`define BE_INSTR_WIDTH 32
`define BE_DATA_WIDTH 32
`define BE_REG_ADDR_WIDTH 5

// Issue queue entries
`define BE_QUEUE_DEPTH 4

// Message type bit plus a 64-bit fetch or exception word
`define BE_FE_MSG_WIDTH 65

// pc, instr, rs1, rs2, imm (5 x 32), decode (8), exception (6)
`define BE_DISP_PKT_WIDTH 174

`endif

// ==== be_pkg.sv ====
`include "be_defs.svh"

package be_pkg;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } be_fe_msg_type_e;

  typedef enum logic [1:0]
  {
    e_instr_access_fault = 2'd0,
    e_instr_page_fault   = 2'd1,
    e_itlb_miss          = 2'd2
  } be_fe_exc_code_e;

  typedef struct packed
  {
    logic [`BE_VADDR_WIDTH-1:0] pc;
    logic [`BE_INSTR_WIDTH-1:0] instr;
  } be_fe_fetch_s;

  // Padded out to the width of the fetch view
  typedef struct packed
  {
    logic [`BE_VADDR_WIDTH-1:0] vaddr;
    be_fe_exc_code_e            exception_code;
    logic [`BE_INSTR_WIDTH-3:0] padding;
  } be_fe_exception_s;

  typedef union packed
  {
    be_fe_fetch_s     fetch;
    be_fe_exception_s exception;
  } be_fe_msg_u;

  typedef struct packed
  {
    be_fe_msg_type_e msg_type;
    be_fe_msg_u      msg;
  } be_fe_queue_s;

  typedef enum logic [1:0]
  {
    e_op_alu_imm = 2'd0,
    e_op_alu_reg = 2'd1,
    e_op_lui     = 2'd2,
    e_op_system  = 2'd3
  } be_op_class_e;

  typedef struct packed
  {
    be_op_class_e op_class;
    logic         rs1_v;
    logic         rs2_v;
    logic         rd_w_v;
    logic [2:0]   funct3;
  } be_decode_s;

  typedef struct packed
  {
    logic illegal_instr;
    logic ecall;
    logic ebreak;
    logic instr_access_fault;
    logic instr_page_fault;
    logic itlb_miss;
  } be_exception_s;

  typedef struct packed
  {
    logic [`BE_VADDR_WIDTH-1:0] pc;
    logic [`BE_INSTR_WIDTH-1:0] instr;
    logic [`BE_DATA_WIDTH-1:0]  rs1;
    logic [`BE_DATA_WIDTH-1:0]  rs2;
    logic [`BE_DATA_WIDTH-1:0]  imm;
    be_decode_s                 decode;
    be_exception_s              exception;
  } be_dispatch_pkt_s;

endpackage

// ==== be_if.sv ====
`timescale 1ns/1ps

// Queue head offered to the scheduler, popped on yumi
interface issue_if;
  logic                v;
  logic                yumi;
  be_pkg::be_fe_queue_s entry;
  logic                flush;

  modport queue_mp (output v, output entry, input yumi, input flush);
  modport sched_mp (input v, input entry, input flush, output yumi);
endinterface

// Scheduler to output side, transfer on v and ready
interface dispatch_if;
  logic                     v;
  logic                     ready;
  be_pkg::be_dispatch_pkt_s pkt;
  logic                     flush;

  modport sched_mp (output v, output pkt, input ready);
  modport out_mp (input v, input pkt, input flush, output ready);
endinterface

// ==== be_issue_queue.sv ====
`timescale 1ns/1ps
`include "be_defs.svh"

module be_issue_queue
  (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        fe_req_i,
  input  logic [`BE_FE_MSG_WIDTH-1:0] fe_msg_i,
  output logic                        fe_ack_o,
  issue_if.queue_mp                   q
  );

  localparam int ptr_w = $clog2(`BE_QUEUE_DEPTH);
  localparam int cnt_w = $clog2(`BE_QUEUE_DEPTH + 1);

  logic [`BE_FE_MSG_WIDTH-1:0] mem [`BE_QUEUE_DEPTH];
  logic [ptr_w-1:0]            wr_ptr;
  logic [ptr_w-1:0]            rd_ptr;
  logic [cnt_w-1:0]            count;
  logic                        ack_r;
  logic                        full;
  logic                        push;
  logic                        pop;

  assign full = (count == cnt_w'(`BE_QUEUE_DEPTH));

  // New request only, and never while flushing
  assign push = fe_req_i & ~ack_r & ~full & ~q.flush;
  assign pop  = q.yumi;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ack_r <= 1'b0;
    end
    else if (push)
    begin
      ack_r <= 1'b1;
    end
    else if (ack_r && !fe_req_i)
    begin
      ack_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || q.flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == ptr_w'(`BE_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == ptr_w'(`BE_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem[wr_ptr] <= fe_msg_i;
    end
  end

  assign fe_ack_o = ack_r;
  assign q.v      = (count != '0);
  assign q.entry  = be_pkg::be_fe_queue_s'(mem[rd_ptr]);

endmodule

// ==== be_regfile.sv ====
`timescale 1ns/1ps
`include "be_defs.svh"

module be_regfile
  (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          w_v_i,
  input  logic [`BE_REG_ADDR_WIDTH-1:0] w_addr_i,
  input  logic [`BE_DATA_WIDTH-1:0]     w_data_i,
  input  logic [`BE_REG_ADDR_WIDTH-1:0] rs1_addr_i,
  input  logic [`BE_REG_ADDR_WIDTH-1:0] rs2_addr_i,
  output logic [`BE_DATA_WIDTH-1:0]     rs1_data_o,
  output logic [`BE_DATA_WIDTH-1:0]     rs2_data_o
  );

  localparam int num_regs = 1 << `BE_REG_ADDR_WIDTH;

  logic [`BE_DATA_WIDTH-1:0] regs [num_regs];

  // x0 reads zero, a same-cycle write is forwarded
  function automatic logic [`BE_DATA_WIDTH-1:0] read_reg
    (input logic [`BE_REG_ADDR_WIDTH-1:0] addr);
    logic [`BE_DATA_WIDTH-1:0] data;
    if (addr == '0)
      data = '0;
    else if (w_v_i && (w_addr_i == addr))
      data = w_data_i;
    else
      data = regs[addr];
    return data;
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
    end
    else if (w_v_i && (w_addr_i != '0))
    begin
      regs[w_addr_i] <= w_data_i;
    end
  end

  always_comb
  begin
    rs1_data_o = read_reg(rs1_addr_i);
    rs2_data_o = read_reg(rs2_addr_i);
  end

endmodule

// ==== be_instr_decoder.sv ====
`timescale 1ns/1ps
`include "be_defs.svh"

module be_instr_decoder
  (
  input  logic [`BE_INSTR_WIDTH-1:0] instr_i,
  output be_pkg::be_decode_s         decode_o,
  output logic [`BE_DATA_WIDTH-1:0]  imm_o,
  output logic                       illegal_o,
  output logic                       ecall_o,
  output logic                       ebreak_o
  );

  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_system = 7'b1110011;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] imm_i;
  logic        sys_base;
  logic        is_ecall;
  logic        is_ebreak;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign imm_i  = instr_i[31:20];

  // rd, rs1 and funct3 all zero
  assign sys_base  = (instr_i[19:7] == '0);
  assign is_ecall  = sys_base & (imm_i == 12'h000);
  assign is_ebreak = sys_base & (imm_i == 12'h001);

  always_comb
  begin
    decode_o  = '0;
    imm_o     = '0;
    illegal_o = 1'b0;
    ecall_o   = 1'b0;
    ebreak_o  = 1'b0;
    case (opcode)
      opc_op_imm:
      begin
        decode_o.op_class = be_pkg::e_op_alu_imm;
        decode_o.rs1_v    = 1'b1;
        decode_o.rd_w_v   = 1'b1;
        decode_o.funct3   = funct3;
        imm_o             = {{(`BE_DATA_WIDTH-12){imm_i[11]}}, imm_i};
      end
      opc_op:
      begin
        decode_o.op_class = be_pkg::e_op_alu_reg;
        decode_o.rs1_v    = 1'b1;
        decode_o.rs2_v    = 1'b1;
        decode_o.rd_w_v   = 1'b1;
        decode_o.funct3   = funct3;
        illegal_o         = (funct7 != 7'h00) && (funct7 != 7'h20);
      end
      opc_lui:
      begin
        decode_o.op_class = be_pkg::e_op_lui;
        decode_o.rd_w_v   = 1'b1;
        imm_o             = {instr_i[31:12], 12'b0};
      end
      opc_system:
      begin
        decode_o.op_class = be_pkg::e_op_system;
        ecall_o           = is_ecall;
        ebreak_o          = is_ebreak;
        illegal_o         = ~(is_ecall | is_ebreak);
      end
      default:
      begin
        illegal_o = 1'b1;
      end
    endcase

    // Illegal encodings carry no decode
    if (illegal_o)
    begin
      decode_o = '0;
      imm_o    = '0;
    end
  end

endmodule

// ==== be_scheduler.sv ====
`timescale 1ns/1ps
`include "be_defs.svh"

module be_scheduler
  (
  issue_if.sched_mp                     q,
  dispatch_if.sched_mp                  d,
  input  logic [`BE_DATA_WIDTH-1:0]     rs1_data_i,
  input  logic [`BE_DATA_WIDTH-1:0]     rs2_data_i,
  output logic [`BE_REG_ADDR_WIDTH-1:0] rs1_addr_o,
  output logic [`BE_REG_ADDR_WIDTH-1:0] rs2_addr_o
  );

  be_pkg::be_fe_fetch_s      fetch;
  be_pkg::be_fe_exception_s  exc;
  logic                      is_fetch;
  be_pkg::be_decode_s        decode;
  logic [`BE_DATA_WIDTH-1:0] imm;
  logic                      illegal;
  logic                      ecall;
  logic                      ebreak;
  be_pkg::be_dispatch_pkt_s  pkt;

  // Both views of the same message word
  assign fetch    = q.entry.msg.fetch;
  assign exc      = q.entry.msg.exception;
  assign is_fetch = (q.entry.msg_type == be_pkg::e_fe_fetch);

  assign rs1_addr_o = fetch.instr[19:15];
  assign rs2_addr_o = fetch.instr[24:20];

  be_instr_decoder instr_decoder
    (
    .instr_i   (fetch.instr),
    .decode_o  (decode),
    .imm_o     (imm),
    .illegal_o (illegal),
    .ecall_o   (ecall),
    .ebreak_o  (ebreak)
    );

  always_comb
  begin
    pkt = '0;
    if (is_fetch)
    begin
      pkt.pc                      = fetch.pc;
      pkt.instr                   = fetch.instr;
      pkt.rs1                     = decode.rs1_v ? rs1_data_i : '0;
      pkt.rs2                     = decode.rs2_v ? rs2_data_i : '0;
      pkt.imm                     = imm;
      pkt.decode                  = decode;
      pkt.exception.illegal_instr = illegal;
      pkt.exception.ecall         = ecall;
      pkt.exception.ebreak        = ebreak;
    end
    else
    begin
      // Faulting address goes out in pc and rs1
      pkt.pc  = exc.vaddr;
      pkt.rs1 = exc.vaddr;
      pkt.exception.instr_access_fault =
        (exc.exception_code == be_pkg::e_instr_access_fault);
      pkt.exception.instr_page_fault =
        (exc.exception_code == be_pkg::e_instr_page_fault);
      pkt.exception.itlb_miss =
        (exc.exception_code == be_pkg::e_itlb_miss);
    end
  end

  assign d.v    = q.v;
  assign d.pkt  = pkt;
  assign q.yumi = q.v & d.ready & ~q.flush;

endmodule

// ==== be_dispatch_out.sv ====
`timescale 1ns/1ps
`include "be_defs.svh"

module be_dispatch_out
  (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  dispatch_if.out_mp                    d,
  output logic                          disp_req_o,
  output logic [`BE_DISP_PKT_WIDTH-1:0] disp_pkt_o,
  input  logic                          disp_ack_i
  );

  typedef enum logic [1:0]
  {
    e_idle         = 2'd0,
    e_req          = 2'd1,
    e_wait_ack_low = 2'd2
  } state_e;

  state_e                   state;
  be_pkg::be_dispatch_pkt_s pkt_r;
  logic                     capture;

  assign d.ready = (state == e_idle);

  // Nothing is taken from the queue during a flush
  assign capture = d.v & d.ready & ~d.flush;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state <= e_idle;
    end
    else
    begin
      case (state)
        e_idle:         if (capture) state <= e_req;
        e_req:          if (disp_ack_i) state <= e_wait_ack_low;
        e_wait_ack_low: if (!disp_ack_i) state <= e_idle;
        default:        state <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (capture)
    begin
      pkt_r <= d.pkt;
    end
  end

  assign disp_req_o = (state == e_req);
  assign disp_pkt_o = pkt_r;

endmodule

// ==== be_top.sv ====
`timescale 1ns/1ps
`include "be_defs.svh"

module be_top
  (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          fe_req_i,
  input  logic [`BE_FE_MSG_WIDTH-1:0]   fe_msg_i,
  output logic                          fe_ack_o,
  input  logic                          flush_i,
  input  logic                          wb_v_i,
  input  logic [`BE_REG_ADDR_WIDTH-1:0] wb_addr_i,
  input  logic [`BE_DATA_WIDTH-1:0]     wb_data_i,
  output logic                          disp_req_o,
  output logic [`BE_DISP_PKT_WIDTH-1:0] disp_pkt_o,
  input  logic                          disp_ack_i
  );

  logic [`BE_REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [`BE_REG_ADDR_WIDTH-1:0] rs2_addr;
  logic [`BE_DATA_WIDTH-1:0]     rs1_data;
  logic [`BE_DATA_WIDTH-1:0]     rs2_data;

  issue_if    iss ();
  dispatch_if disp ();

  assign iss.flush  = flush_i;
  assign disp.flush = flush_i;

  be_issue_queue issue_queue
    (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .fe_req_i (fe_req_i),
    .fe_msg_i (fe_msg_i),
    .fe_ack_o (fe_ack_o),
    .q        (iss)
    );

  be_scheduler scheduler
    (
    .q          (iss),
    .d          (disp),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr)
    );

  be_regfile int_regfile
    (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .w_v_i      (wb_v_i),
    .w_addr_i   (wb_addr_i),
    .w_data_i   (wb_data_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
    );

  be_dispatch_out dispatch_out
    (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .d          (disp),
    .disp_req_o (disp_req_o),
    .disp_pkt_o (disp_pkt_o),
    .disp_ack_i (disp_ack_i)
    );

endmodule

// ==== tb_be_top.sv ====
`timescale 1ns/1ps
`include "be_defs.svh"

module tb_be_top;

  localparam int clk_half = 20;

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          fe_req_i;
  logic [`BE_FE_MSG_WIDTH-1:0]   fe_msg_i;
  logic                          fe_ack_o;
  logic                          flush_i;
  logic                          wb_v_i;
  logic [`BE_REG_ADDR_WIDTH-1:0] wb_addr_i;
  logic [`BE_DATA_WIDTH-1:0]     wb_data_i;
  logic                          disp_req_o;
  logic [`BE_DISP_PKT_WIDTH-1:0] disp_pkt_o;
  logic                          disp_ack_i;

  integer                    seed = 95;
  int                        errors = 0;
  int                        checks = 0;
  int                        n_sent = 0;
  int                        cycles = 0;
  logic                      ack_hold = 1'b0;
  logic                      req_prev = 1'b0;
  logic [31:0]               pc_next = 32'h0000_1000;
  logic [`BE_DATA_WIDTH-1:0] reg_model [32];
  be_pkg::be_dispatch_pkt_s  exp_q [$];

  be_top dut
    (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .fe_req_i   (fe_req_i),
    .fe_msg_i   (fe_msg_i),
    .fe_ack_o   (fe_ack_o),
    .flush_i    (flush_i),
    .wb_v_i     (wb_v_i),
    .wb_addr_i  (wb_addr_i),
    .wb_data_i  (wb_data_i),
    .disp_req_o (disp_req_o),
    .disp_pkt_o (disp_pkt_o),
    .disp_ack_i (disp_ack_i)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #clk_half clk_i = ~clk_i;
  end

  // Expected dispatch packet for one fetch message
  function automatic be_pkg::be_dispatch_pkt_s be_expect
    (input logic [`BE_FE_MSG_WIDTH-1:0] msg);
    be_pkg::be_dispatch_pkt_s p;
    logic [31:0]              ins;
    p = '0;
    ins = msg[31:0];
    p.pc = msg[63:32];
    if (msg[64])
    begin
      p.rs1 = msg[63:32];
      case (msg[31:30])
        2'd0: p.exception.instr_access_fault = 1'b1;
        2'd1: p.exception.instr_page_fault = 1'b1;
        2'd2: p.exception.itlb_miss = 1'b1;
        default: p.exception = '0;
      endcase
    end
    else
    begin
      p.instr = ins;
      case (ins[6:0])
        7'h13:
        begin
          p.decode.op_class = be_pkg::e_op_alu_imm;
          p.decode.rs1_v = 1'b1;
          p.decode.rd_w_v = 1'b1;
          p.decode.funct3 = ins[14:12];
          p.imm = {{20{ins[31]}}, ins[31:20]};
        end
        7'h33:
        begin
          if (ins[31:25] == 7'h00 || ins[31:25] == 7'h20)
          begin
            p.decode.op_class = be_pkg::e_op_alu_reg;
            p.decode.rs1_v = 1'b1;
            p.decode.rs2_v = 1'b1;
            p.decode.rd_w_v = 1'b1;
            p.decode.funct3 = ins[14:12];
          end
          else
            p.exception.illegal_instr = 1'b1;
        end
        7'h37:
        begin
          p.decode.op_class = be_pkg::e_op_lui;
          p.decode.rd_w_v = 1'b1;
          p.imm = {ins[31:12], 12'h000};
        end
        7'h73:
        begin
          p.decode.op_class = be_pkg::e_op_system;
          if (ins == 32'h0000_0073)
            p.exception.ecall = 1'b1;
          else if (ins == 32'h0010_0073)
            p.exception.ebreak = 1'b1;
          else
          begin
            p.decode = '0;
            p.exception.illegal_instr = 1'b1;
          end
        end
        default: p.exception.illegal_instr = 1'b1;
      endcase
      if (p.decode.rs1_v)
        p.rs1 = reg_model[ins[19:15]];
      if (p.decode.rs2_v)
        p.rs2 = reg_model[ins[24:20]];
    end
    return p;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic compare_pkt(input be_pkg::be_dispatch_pkt_s exp,
                             input be_pkg::be_dispatch_pkt_s act);
    check_value("disp_pkt_o.pc", exp.pc, act.pc);
    check_value("disp_pkt_o.instr", exp.instr, act.instr);
    check_value("disp_pkt_o.rs1", exp.rs1, act.rs1);
    check_value("disp_pkt_o.rs2", exp.rs2, act.rs2);
    check_value("disp_pkt_o.imm", exp.imm, act.imm);
    check_value("disp_pkt_o.decode", 32'(exp.decode), 32'(act.decode));
    check_value("disp_pkt_o.exception", 32'(exp.exception), 32'(act.exception));
  endtask

  task automatic post_msg(input logic [`BE_FE_MSG_WIDTH-1:0] msg);
    exp_q.push_back(be_expect(msg));
    n_sent++;
    @(posedge clk_i);
    fe_msg_i <= msg;
    fe_req_i <= 1'b1;
  endtask

  task automatic finish_fetch();
    do
      @(negedge clk_i);
    while (!fe_ack_o);
    @(posedge clk_i);
    fe_req_i <= 1'b0;
    do
      @(negedge clk_i);
    while (fe_ack_o);
  endtask

  task automatic send_msg(input logic [`BE_FE_MSG_WIDTH-1:0] msg);
    post_msg(msg);
    finish_fetch();
  endtask

  task automatic send_instr(input logic [31:0] ins);
    send_msg({1'b0, pc_next, ins});
    pc_next += 32'd4;
  endtask

  // Random OP-IMM, OP or LUI with sources in x0..x7
  task automatic rand_alu(output logic [31:0] ins);
    logic [31:0] r;
    int          kind;
    r = $random(seed);
    kind = {$random(seed)} % 3;
    case (kind)
      0: ins = {r[31:20], 2'b00, r[2:0], r[14:12], r[11:7], 7'h13};
      1: ins = {1'b0, r[30], 5'b0, 2'b00, r[5:3], 2'b00, r[2:0], r[14:12], r[11:7], 7'h33};
      default: ins = {r[31:12], r[11:7], 7'h37};
    endcase
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    wb_v_i <= 1'b1;
    wb_addr_i <= addr;
    wb_data_i <= data;
    if (addr != 5'd0)
      reg_model[addr] = data;
    @(posedge clk_i);
    wb_v_i <= 1'b0;
  endtask

  // Writeback lands in the cycle the queue head is issued
  task automatic same_cycle_wb(input logic [4:0] addr, input logic [31:0] data);
    logic [`BE_FE_MSG_WIDTH-1:0] msg;
    msg = {1'b0, pc_next, 7'h00, addr, addr, 3'b000, 5'd9, 7'h33};
    pc_next += 32'd4;
    reg_model[addr] = data;
    post_msg(msg);
    @(posedge clk_i);
    wb_v_i <= 1'b1;
    wb_addr_i <= addr;
    wb_data_i <= data;
    @(posedge clk_i);
    wb_v_i <= 1'b0;
    finish_fetch();
  endtask

  task automatic drain();
    do
      @(negedge clk_i);
    while (exp_q.size() != 0 || disp_req_o || disp_ack_i);
    @(negedge clk_i);
  endtask

  // Dispatch side ack with a random delay
  initial
  begin
    int delay;
    forever
    begin
      @(negedge clk_i);
      if (disp_req_o && !ack_hold)
      begin
        delay = {$random(seed)} % 4;
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        disp_ack_i <= 1'b1;
        do
          @(negedge clk_i);
        while (disp_req_o);
        @(posedge clk_i);
        disp_ack_i <= 1'b0;
      end
    end
  end

  initial
  begin
    be_pkg::be_dispatch_pkt_s exp;
    forever
    begin
      @(negedge clk_i);
      if (disp_req_o && !req_prev)
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("Error: dispatch request at %0t with no packet expected", $time);
        end
        else
        begin
          exp = exp_q.pop_front();
          compare_pkt(exp, be_pkg::be_dispatch_pkt_s'(disp_pkt_o));
        end
      end
      req_prev = disp_req_o;
    end
  end

  initial
  begin
    while (cycles < 40 * n_sent + 200)
    begin
      @(posedge clk_i);
      cycles++;
    end
    errors++;
    $display("Timeout: run stopped after %0d cycles without finishing", cycles);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Errors found");
    $finish;
  end

  initial
  begin
    logic [31:0] ins;
    rst_n_i = 1'b0;
    fe_req_i = 1'b0;
    fe_msg_i = '0;
    flush_i = 1'b0;
    wb_v_i = 1'b0;
    wb_addr_i = '0;
    wb_data_i = '0;
    disp_ack_i = 1'b0;
    for (int i = 0; i < 32; i++)
      reg_model[i] = '0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    for (int i = 0; i < 10; i++)
      write_reg(5'({$random(seed)} % 8), $random(seed));
    // x0 keeps reading zero after a write
    write_reg(5'd0, 32'hdead_beef);
    send_instr(32'h0000_00b3);
    for (int i = 0; i < 16; i++)
    begin
      rand_alu(ins);
      send_instr(ins);
    end

    // ECALL, EBREAK, bad SYSTEM, bad funct7, random opcodes
    send_instr(32'h0000_0073);
    send_instr(32'h0010_0073);
    send_instr(32'h0020_0073);
    send_instr(32'h4200_00b3);
    for (int i = 0; i < 6; i++)
    begin
      ins = $random(seed);
      if (ins[6:0] inside {7'h13, 7'h33, 7'h37, 7'h73})
        ins[6:0] = ins[6:0] ^ 7'h08;
      send_instr(ins);
    end
    for (int c = 0; c < 3; c++)
      send_msg({1'b1, $random(seed), 2'(c), 30'h0});
    drain();

    // Sender stalls once the output register and four entries are full
    ack_hold = 1'b1;
    for (int i = 0; i < 5; i++)
    begin
      rand_alu(ins);
      send_instr(ins);
    end
    rand_alu(ins);
    post_msg({1'b0, pc_next, ins});
    pc_next += 32'd4;
    repeat (8)
    begin
      @(negedge clk_i);
      check_value("fe_ack_o", 32'd0, 32'(fe_ack_o));
    end
    ack_hold = 1'b0;
    finish_fetch();
    drain();

    ack_hold = 1'b1;
    for (int i = 0; i < 5; i++)
    begin
      rand_alu(ins);
      send_instr(ins);
    end
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    exp_q.delete();
    @(negedge clk_i);
    check_value("disp_req_o", 32'd1, 32'(disp_req_o));
    ack_hold = 1'b0;
    for (int i = 0; i < 3; i++)
    begin
      rand_alu(ins);
      send_instr(ins);
    end
    drain();

    write_reg(5'd5, 32'h1111_1111);
    same_cycle_wb(5'd5, 32'hcafe_0005);
    drain();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
be_pkg.sv
be_if.sv
be_issue_queue.sv
be_regfile.sv
be_instr_decoder.sv
be_scheduler.sv
be_dispatch_out.sv
be_top.sv
tb_be_top.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; the status follows the testbench result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_be_top -o tb_be_top &&
  ./obj_dir/tb_be_top | tee /dev/stderr | grep -qx "No errors" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
